// File: rtl/cache_pkg.sv
package cache_pkg;

  // ----------------------------------------
  // geometry
  // ----------------------------------------

  // byte address and processor word
  localparam int addr_w   = 32;
  localparam int word_w   = 32;
  // one memory transfer is a whole line
  localparam int line_w   = 128;
  localparam int opaque_w = 8;

  // 256 bytes as 16 lines of 16 bytes
  localparam int num_lines  = 16;
  localparam int index_w    = 4;
  // byte offset bits inside a line
  localparam int offset_w   = 4;
  // word position inside a line
  localparam int word_sel_w = 2;
  // remaining upper address bits
  localparam int tag_w      = addr_w - index_w - offset_w;

  // ----------------------------------------
  // encodings
  // ----------------------------------------

  // message type on all four ports
  typedef enum logic [2:0] {
    read  = 3'd0,
    write = 3'd1,
    init  = 3'd2
  } mem_type_e;

  // controller states
  typedef enum logic [2:0] {
    idle        = 3'd0,
    tag_check   = 3'd1,
    evict_req   = 3'd2,
    evict_wait  = 3'd3,
    refill_req  = 3'd4,
    refill_wait = 3'd5,
    resp        = 3'd6
  } cache_state_e;

  // ----------------------------------------
  // messages
  // ----------------------------------------

  // processor side request
  typedef struct packed {
    mem_type_e             msg_type;
    logic [opaque_w-1:0]   opaque;
    logic [addr_w-1:0]     addr;
    logic [word_w-1:0]     data;
  } cache_req_t;

  // processor side response, data only meaningful for reads
  typedef struct packed {
    mem_type_e             msg_type;
    logic [opaque_w-1:0]   opaque;
    logic [word_w-1:0]     data;
  } cache_resp_t;

  // memory side request
  // addr is the byte address of the line with the offset bits zero
  typedef struct packed {
    mem_type_e             msg_type;
    logic [opaque_w-1:0]   opaque;
    logic [addr_w-1:0]     addr;
    logic [line_w-1:0]     data;
  } mem_req_t;

  // memory side response
  typedef struct packed {
    mem_type_e             msg_type;
    logic [opaque_w-1:0]   opaque;
    logic [line_w-1:0]     data;
  } mem_resp_t;

endpackage

// File: rtl/cache_tag_array.sv
`timescale 1ns/1ps

module cache_tag_array (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [cache_pkg::index_w-1:0] index,
  input  logic [cache_pkg::tag_w-1:0]   tag,
  input  logic                          fill_en,
  input  logic                          write_mark_en,
  output logic                          hit,
  output logic                          victim_dirty,
  output logic [cache_pkg::tag_w-1:0]   victim_tag
);

  // per line state
  logic [cache_pkg::num_lines-1:0] valid;
  logic [cache_pkg::num_lines-1:0] dirty;
  logic [cache_pkg::tag_w-1:0]     tags [cache_pkg::num_lines];

  // ----------------------------------------
  // valid and dirty bits
  // ----------------------------------------

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      valid <= '0;
      dirty <= '0;
    end
    else if (fill_en)
    begin
      // fresh line from memory is clean
      valid[index] <= 1'b1;
      dirty[index] <= 1'b0;
    end
    else if (write_mark_en)
    begin
      dirty[index] <= 1'b1;
    end
  end

  // tag storage
  always_ff @(posedge clk)
  begin
    if (fill_en)
      tags[index] <= tag;
  end

  // ----------------------------------------
  // lookup
  // ----------------------------------------

  assign hit          = valid[index] && (tags[index] == tag);
  // only a valid line needs a writeback
  assign victim_dirty = valid[index] && dirty[index];
  assign victim_tag   = tags[index];

endmodule

// File: rtl/cache_data_array.sv
`timescale 1ns/1ps

module cache_data_array (
  input  logic                             clk,
  input  logic [cache_pkg::index_w-1:0]    index,
  input  logic [cache_pkg::word_sel_w-1:0] word_sel,
  input  logic                             fill_en,
  input  logic [cache_pkg::line_w-1:0]     fill_line,
  input  logic                             word_wr_en,
  input  logic [cache_pkg::word_w-1:0]     wr_word,
  output logic [cache_pkg::word_w-1:0]     rd_word,
  output logic [cache_pkg::line_w-1:0]     victim_line
);

  // line storage
  logic [cache_pkg::line_w-1:0] lines [cache_pkg::num_lines];

  // addressed line
  logic [cache_pkg::line_w-1:0] cur_line;

  // ----------------------------------------
  // write side
  // ----------------------------------------

  always_ff @(posedge clk)
  begin
    if (fill_en)
    begin
      // refill overwrites the whole line
      lines[index] <= fill_line;
    end
    else if (word_wr_en)
    begin
      // merge one word into its slot
      lines[index][word_sel*cache_pkg::word_w +: cache_pkg::word_w] <= wr_word;
    end
  end

  // ----------------------------------------
  // read side
  // ----------------------------------------

  assign cur_line = lines[index];

  // word 0 sits in the low bits of the line
  always_comb
  begin
    rd_word = cur_line[word_sel*cache_pkg::word_w +: cache_pkg::word_w];
  end

  // whole line for eviction
  assign victim_line = cur_line;

endmodule

// File: rtl/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
  input  logic                             clk,
  input  logic                             rst_n,
  // processor request
  input  cache_pkg::cache_req_t            cache_req,
  input  logic                             cache_req_val,
  output logic                             cache_req_rdy,
  // processor response
  output cache_pkg::cache_resp_t           cache_resp,
  output logic                             cache_resp_val,
  input  logic                             cache_resp_rdy,
  // memory request
  output cache_pkg::mem_req_t              mem_req,
  output logic                             mem_req_val,
  input  logic                             mem_req_rdy,
  // memory response
  input  cache_pkg::mem_resp_t             mem_resp,
  input  logic                             mem_resp_val,
  output logic                             mem_resp_rdy,
  // tag array
  input  logic                             hit,
  input  logic                             victim_dirty,
  input  logic [cache_pkg::tag_w-1:0]      victim_tag,
  // data array
  input  logic [cache_pkg::word_w-1:0]     rd_word,
  input  logic [cache_pkg::line_w-1:0]     victim_line,
  // array addressing
  output logic [cache_pkg::index_w-1:0]    index,
  output logic [cache_pkg::tag_w-1:0]      tag,
  output logic [cache_pkg::word_sel_w-1:0] word_sel,
  // array updates
  output logic                             tag_fill_en,
  output logic                             write_mark_en,
  output logic                             data_fill_en,
  output logic                             word_wr_en,
  output logic [cache_pkg::line_w-1:0]     fill_line,
  output logic [cache_pkg::word_w-1:0]     wr_word
);

  cache_pkg::cache_state_e state;
  cache_pkg::cache_state_e state_nxt;

  // accepted request, held until the response leaves
  cache_pkg::cache_req_t req_q;
  // word returned to the processor
  logic [cache_pkg::word_w-1:0] resp_data_q;

  // write and init both store a word
  logic is_store;

  // ----------------------------------------
  // address split
  // ----------------------------------------

  assign word_sel = req_q.addr[cache_pkg::offset_w-1 -: cache_pkg::word_sel_w];
  assign index    = req_q.addr[cache_pkg::offset_w +: cache_pkg::index_w];
  assign tag      = req_q.addr[cache_pkg::offset_w+cache_pkg::index_w +: cache_pkg::tag_w];

  assign is_store = (req_q.msg_type == cache_pkg::write) ||
                    (req_q.msg_type == cache_pkg::init);

  // ----------------------------------------
  // registers
  // ----------------------------------------

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state <= cache_pkg::idle;
    else
      state <= state_nxt;
  end

  // capture on the accepting edge
  always_ff @(posedge clk)
  begin
    if (cache_req_val && cache_req_rdy)
      req_q <= cache_req;
  end

  // read data taken at the hit
  always_ff @(posedge clk)
  begin
    if (state == cache_pkg::tag_check && hit)
      resp_data_q <= is_store ? '0 : rd_word;
  end

  // ----------------------------------------
  // next state
  // ----------------------------------------

  always_comb
  begin
    state_nxt = state;
    case (state)
      cache_pkg::idle:
      begin
        if (cache_req_val)
          state_nxt = cache_pkg::tag_check;
      end
      cache_pkg::tag_check:
      begin
        // dirty victim goes out before the refill
        if (hit)
          state_nxt = cache_pkg::resp;
        else if (victim_dirty)
          state_nxt = cache_pkg::evict_req;
        else
          state_nxt = cache_pkg::refill_req;
      end
      cache_pkg::evict_req:
      begin
        if (mem_req_rdy)
          state_nxt = cache_pkg::evict_wait;
      end
      cache_pkg::evict_wait:
      begin
        if (mem_resp_val)
          state_nxt = cache_pkg::refill_req;
      end
      cache_pkg::refill_req:
      begin
        if (mem_req_rdy)
          state_nxt = cache_pkg::refill_wait;
      end
      cache_pkg::refill_wait:
      begin
        // second lookup is a hit
        if (mem_resp_val)
          state_nxt = cache_pkg::tag_check;
      end
      cache_pkg::resp:
      begin
        if (cache_resp_rdy)
          state_nxt = cache_pkg::idle;
      end
      default:
      begin
        state_nxt = cache_pkg::idle;
      end
    endcase
  end

  // ----------------------------------------
  // handshakes and array strobes
  // ----------------------------------------

  assign cache_req_rdy  = (state == cache_pkg::idle);
  assign cache_resp_val = (state == cache_pkg::resp);
  assign mem_req_val    = (state == cache_pkg::evict_req) ||
                          (state == cache_pkg::refill_req);
  assign mem_resp_rdy   = (state == cache_pkg::evict_wait) ||
                          (state == cache_pkg::refill_wait);

  // store hit merges the word and marks the line
  assign word_wr_en    = (state == cache_pkg::tag_check) && hit && is_store;
  assign write_mark_en = word_wr_en;
  // refill lands when memory answers
  assign data_fill_en  = (state == cache_pkg::refill_wait) && mem_resp_val;
  assign tag_fill_en   = data_fill_en;

  assign fill_line = mem_resp.data;
  assign wr_word   = req_q.data;

  // ----------------------------------------
  // messages
  // ----------------------------------------

  // type and opaque echo the request
  assign cache_resp.msg_type = req_q.msg_type;
  assign cache_resp.opaque   = req_q.opaque;
  assign cache_resp.data     = resp_data_q;

  always_comb
  begin
    mem_req.opaque = req_q.opaque;
    if (state == cache_pkg::evict_req)
    begin
      // writeback address rebuilt from the stored tag
      mem_req.msg_type = cache_pkg::write;
      mem_req.addr     = {victim_tag, index, {cache_pkg::offset_w{1'b0}}};
      mem_req.data     = victim_line;
    end
    else
    begin
      // line that holds the requested word
      mem_req.msg_type = cache_pkg::read;
      mem_req.addr     = {req_q.addr[cache_pkg::addr_w-1:cache_pkg::offset_w],
                          {cache_pkg::offset_w{1'b0}}};
      mem_req.data     = '0;
    end
  end

endmodule

// File: rtl/blocking_cache.sv
`timescale 1ns/1ps

module blocking_cache (
  input  logic                   clk,
  input  logic                   rst_n,
  // processor side
  input  cache_pkg::cache_req_t  cache_req,
  input  logic                   cache_req_val,
  output logic                   cache_req_rdy,
  output cache_pkg::cache_resp_t cache_resp,
  output logic                   cache_resp_val,
  input  logic                   cache_resp_rdy,
  // memory side
  output cache_pkg::mem_req_t    mem_req,
  output logic                   mem_req_val,
  input  logic                   mem_req_rdy,
  input  cache_pkg::mem_resp_t   mem_resp,
  input  logic                   mem_resp_val,
  output logic                   mem_resp_rdy
);

  // ----------------------------------------
  // array lookup results
  // ----------------------------------------

  logic                             hit;
  logic                             victim_dirty;
  logic [cache_pkg::tag_w-1:0]      victim_tag;
  logic [cache_pkg::word_w-1:0]     rd_word;
  logic [cache_pkg::line_w-1:0]     victim_line;

  // addressing and updates from the controller
  logic [cache_pkg::index_w-1:0]    index;
  logic [cache_pkg::tag_w-1:0]      tag;
  logic [cache_pkg::word_sel_w-1:0] word_sel;
  logic                             tag_fill_en;
  logic                             write_mark_en;
  logic                             data_fill_en;
  logic                             word_wr_en;
  logic [cache_pkg::line_w-1:0]     fill_line;
  logic [cache_pkg::word_w-1:0]     wr_word;

  // ----------------------------------------
  // instances
  // ----------------------------------------

  cache_ctrl i_cache_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .cache_req      (cache_req),
    .cache_req_val  (cache_req_val),
    .cache_req_rdy  (cache_req_rdy),
    .cache_resp     (cache_resp),
    .cache_resp_val (cache_resp_val),
    .cache_resp_rdy (cache_resp_rdy),
    .mem_req        (mem_req),
    .mem_req_val    (mem_req_val),
    .mem_req_rdy    (mem_req_rdy),
    .mem_resp       (mem_resp),
    .mem_resp_val   (mem_resp_val),
    .mem_resp_rdy   (mem_resp_rdy),
    .hit            (hit),
    .victim_dirty   (victim_dirty),
    .victim_tag     (victim_tag),
    .rd_word        (rd_word),
    .victim_line    (victim_line),
    .index          (index),
    .tag            (tag),
    .word_sel       (word_sel),
    .tag_fill_en    (tag_fill_en),
    .write_mark_en  (write_mark_en),
    .data_fill_en   (data_fill_en),
    .word_wr_en     (word_wr_en),
    .fill_line      (fill_line),
    .wr_word        (wr_word)
  );

  // valid, dirty and tag per line
  cache_tag_array i_cache_tag_array (
    .clk           (clk),
    .rst_n         (rst_n),
    .index         (index),
    .tag           (tag),
    .fill_en       (tag_fill_en),
    .write_mark_en (write_mark_en),
    .hit           (hit),
    .victim_dirty  (victim_dirty),
    .victim_tag    (victim_tag)
  );

  // line data
  cache_data_array i_cache_data_array (
    .clk         (clk),
    .index       (index),
    .word_sel    (word_sel),
    .fill_en     (data_fill_en),
    .fill_line   (fill_line),
    .word_wr_en  (word_wr_en),
    .wr_word     (wr_word),
    .rd_word     (rd_word),
    .victim_line (victim_line)
  );

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  // 40 ns period
  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // reset low for two rising edges, released on a falling edge
  initial
  begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// File: verif/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cache_pkg::mem_req_t  mem_req,
  input  logic                 mem_req_val,
  output logic                 mem_req_rdy,
  output cache_pkg::mem_resp_t mem_resp,
  output logic                 mem_resp_val,
  input  logic                 mem_resp_rdy
);

  // 256 lines cover byte addresses 0x000 to 0xfff
  logic [cache_pkg::line_w-1:0] lines [256];

  integer               seed = 32'h536c_1735;
  int                   delay = 0;
  logic                 busy = 1'b0;
  // request side refuses a transfer now and then
  logic                 req_stall = 1'b0;
  logic                 resp_val = 1'b0;
  logic                 req_fire = 1'b0;
  logic                 resp_fire = 1'b0;
  cache_pkg::mem_req_t  req_q;
  cache_pkg::mem_resp_t resp_q = '0;

  assign mem_req_rdy  = rst_n && !busy && !req_stall;
  assign mem_resp_val = resp_val;
  assign mem_resp     = resp_q;

  // each word derived from its own byte address
  initial
  begin
    for (int a = 0; a < 4096; a += 4)
      lines[a/16][(a%16)*8 +: 32] = {4'hc, a[11:0], 4'h3, ~a[11:0]};
  end

  // ----------------------------------------
  // handshakes seen at the rising edge
  // ----------------------------------------

  always @(posedge clk)
  begin
    req_fire  <= mem_req_val && mem_req_rdy;
    resp_fire <= mem_resp_val && mem_resp_rdy;
    if (mem_req_val && mem_req_rdy)
      req_q <= mem_req;
  end

  // outputs change on the falling edge only
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      busy      = 1'b0;
      resp_val  = 1'b0;
      req_stall = 1'b0;
    end
    else
    begin
      if (resp_fire)
      begin
        busy     = 1'b0;
        resp_val = 1'b0;
      end
      if (req_fire)
      begin
        busy            = 1'b1;
        delay           = $random(seed) & 7;
        resp_q.msg_type = req_q.msg_type;
        resp_q.opaque   = req_q.opaque;
        if (req_q.msg_type == cache_pkg::write)
        begin
          lines[req_q.addr[11:4]] = req_q.data;
          resp_q.data             = '0;
        end
        else
          resp_q.data = lines[req_q.addr[11:4]];
      end
      // access delay counts down before the answer
      if (busy && !resp_val)
      begin
        if (delay == 0)
          resp_val = 1'b1;
        else
          delay--;
      end
      // about one cycle in four not ready for a request
      req_stall = ($random(seed) & 3) == 0;
    end
  end

  // replace one line before the cache asks for it
  task automatic preload_line(input logic [cache_pkg::addr_w-1:0] addr,
                              input logic [cache_pkg::line_w-1:0] data);
    lines[addr[11:4]] = data;
  endtask

endmodule

// File: verif/tb_blocking_cache.sv
`timescale 1ns/1ps

module tb_blocking_cache;

  logic clk;
  logic rst_n;

  cache_pkg::cache_req_t  cache_req;
  logic                   cache_req_val;
  logic                   cache_req_rdy;
  cache_pkg::cache_resp_t cache_resp;
  logic                   cache_resp_val;
  logic                   cache_resp_rdy;
  cache_pkg::mem_req_t    mem_req;
  logic                   mem_req_val;
  logic                   mem_req_rdy;
  cache_pkg::mem_resp_t   mem_resp;
  logic                   mem_resp_val;
  logic                   mem_resp_rdy;

  int     timeout_cycles = 200;
  integer seed = 32'h536c_1735;
  int     errors = 0;
  int     checks = 0;
  int     test_errors = 0;
  bit     timed_out = 1'b0;
  // random stalls on cache_resp_rdy
  bit     stall_en = 1'b0;

  // expected word per byte address
  logic [31:0] ref_mem [int unsigned];

  // writebacks seen on the memory port
  int                           wb_count = 0;
  logic [cache_pkg::addr_w-1:0] wb_addr;
  logic [cache_pkg::line_w-1:0] wb_data;

  tb_clk_gen i_tb_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  tb_mem_model i_tb_mem_model (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_req      (mem_req),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp     (mem_resp),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy)
  );

  blocking_cache i_blocking_cache (
    .clk            (clk),
    .rst_n          (rst_n),
    .cache_req      (cache_req),
    .cache_req_val  (cache_req_val),
    .cache_req_rdy  (cache_req_rdy),
    .cache_resp     (cache_resp),
    .cache_resp_val (cache_resp_val),
    .cache_resp_rdy (cache_resp_rdy),
    .mem_req        (mem_req),
    .mem_req_val    (mem_req_val),
    .mem_req_rdy    (mem_req_rdy),
    .mem_resp       (mem_resp),
    .mem_resp_val   (mem_resp_val),
    .mem_resp_rdy   (mem_resp_rdy)
  );

  // ----------------------------------------
  // protocol assertions
  // ----------------------------------------

  // response held while the processor stalls
  resp_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
    cache_resp_val && !cache_resp_rdy |=> cache_resp_val && $stable(cache_resp))
  else
  begin
    errors++;
    $display("cache response changed while stalled, time %0t", $time);
  end

  // one request in flight
  req_block_a : assert property (@(posedge clk) disable iff (!rst_n)
    cache_resp_val |-> !cache_req_rdy)
  else
  begin
    errors++;
    $display("cache_req_rdy high with a response pending, time %0t", $time);
  end

  // memory request held until taken
  mem_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_val && !mem_req_rdy |=> mem_req_val && $stable(mem_req))
  else
  begin
    errors++;
    $display("memory request changed before transfer, time %0t", $time);
  end

  always @(posedge clk)
  begin
    if (mem_req_val && mem_req_rdy && mem_req.msg_type == cache_pkg::write)
    begin
      wb_count <= wb_count + 1;
      wb_addr  <= mem_req.addr;
      wb_data  <= mem_req.data;
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  task automatic check_val(input string name, input logic [127:0] expected,
                           input logic [127:0] actual);
    checks++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("MISMATCH time %0t %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout after %0d cycles waiting for %s", timeout_cycles, what);
    errors++;
    timed_out = 1'b1;
    // the run is closed by the timeout block
    forever @(negedge clk);
  endtask

  task automatic send_req(input cache_pkg::mem_type_e msg_type, input logic [7:0] opaque,
                          input logic [31:0] addr, input logic [31:0] data);
    int n;
    n                  = 0;
    cache_req.msg_type = msg_type;
    cache_req.opaque   = opaque;
    cache_req.addr     = addr;
    cache_req.data     = data;
    cache_req_val      = 1'b1;
    while (!cache_req_rdy && n < timeout_cycles)
    begin
      @(negedge clk);
      n++;
    end
    if (!cache_req_rdy)
      timeout_fail("cache_req_rdy");
    // accepted on the rising edge in between
    @(negedge clk);
    cache_req_val = 1'b0;
  endtask

  // hold keeps cache_resp_rdy low for that many cycles of cache_resp_val
  task automatic get_resp(input int hold, output cache_pkg::cache_resp_t resp,
                          output int latency);
    int n;
    int left;
    bit done;
    n       = 1;
    left    = hold;
    done    = 1'b0;
    latency = 0;
    while (!done && n <= timeout_cycles)
    begin
      if (cache_resp_val)
      begin
        if (latency == 0)
          latency = n;
        if (left > 0)
        begin
          cache_resp_rdy = 1'b0;
          left--;
        end
        else if (stall_en)
          cache_resp_rdy = ($random(seed) & 1) != 0;
        else
          cache_resp_rdy = 1'b1;
        if (cache_resp_rdy)
        begin
          resp = cache_resp;
          done = 1'b1;
        end
      end
      @(negedge clk);
      n++;
    end
    if (!done)
      timeout_fail("cache_resp_val");
    else
      cache_resp_rdy = 1'b1;
  endtask

  // one request and its response, checked against ref_mem
  task automatic access(input cache_pkg::mem_type_e msg_type, input logic [7:0] opaque,
                        input logic [31:0] addr, input logic [31:0] data,
                        input int hold, output int latency);
    cache_pkg::cache_resp_t resp;
    send_req(msg_type, opaque, addr, data);
    get_resp(hold, resp, latency);
    check_val("cache_resp.msg_type", msg_type, resp.msg_type);
    check_val("cache_resp.opaque", opaque, resp.opaque);
    if (msg_type == cache_pkg::read)
      check_val("cache_resp.data", ref_mem[addr], resp.data);
    else
      ref_mem[addr] = data;
  endtask

  task automatic end_test(input string name);
    $display("test %s finished with %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------

  initial
  begin
    int                           lat;
    int                           n;
    int                           wb_before;
    logic [cache_pkg::line_w-1:0] line;
    cache_req      = '0;
    cache_req_val  = 1'b0;
    cache_resp_rdy = 1'b1;
    n              = 0;
    while (rst_n !== 1'b1 && n < timeout_cycles)
    begin
      @(negedge clk);
      n++;
    end
    if (rst_n !== 1'b1)
      timeout_fail("reset release");

    // idle after reset
    check_val("cache_resp_val", 1'b0, cache_resp_val);
    check_val("mem_req_val", 1'b0, mem_req_val);
    check_val("cache_req_rdy", 1'b1, cache_req_rdy);
    end_test("reset");

    // index 0 still invalid, so a clean miss
    line = {32'h7310_010c, 32'h7310_0108, 32'h7310_0104, 32'h7310_0100};
    i_tb_mem_model.preload_line(32'h100, line);
    for (int w = 0; w < 4; w++)
      ref_mem[32'h100 + 4*w] = line[32*w +: 32];
    stall_en = 1'b1;
    for (int w = 0; w < 4; w++)
      access(cache_pkg::read, 8'h40 + w, 32'h100 + 4*w, 32'h0, 0, lat);
    end_test("clean_read_miss");

    // line 0 replaces the clean 0x100 line
    stall_en = 1'b0;
    for (int w = 0; w < 4; w++)
      access(cache_pkg::init, 8'h10 + w, 4*w, 32'h0ace_0000 + 17*w, 0, lat);
    for (int w = 0; w < 4; w++)
      access(cache_pkg::read, 8'h20 + w, 4*w, 32'h0, 0, lat);
    end_test("init_then_read");

    access(cache_pkg::write, 8'h30, 32'h4, 32'hbeef_0004, 0, lat);
    access(cache_pkg::read, 8'h31, 32'h4, 32'h0, 0, lat);
    check_val("hit latency", 2, lat);
    end_test("write_hit_then_read");

    // dirty line 0 must go out before 0x100 comes in
    stall_en = 1'b1;
    access(cache_pkg::write, 8'h50, 32'h8, 32'hc0ff_ee08, 0, lat);
    wb_before = wb_count;
    access(cache_pkg::read, 8'h51, 32'h100, 32'h0, 0, lat);
    check_val("writeback count", wb_before + 1, wb_count);
    check_val("mem_req.addr", 32'h0, wb_addr);
    check_val("mem_req.data", {ref_mem[12], ref_mem[8], ref_mem[4], ref_mem[0]}, wb_data);
    access(cache_pkg::read, 8'h52, 32'h8, 32'h0, 0, lat);
    access(cache_pkg::read, 8'h53, 32'h0, 32'h0, 0, lat);
    end_test("dirty_miss");

    // stall a hit for several cycles
    stall_en = 1'b0;
    access(cache_pkg::read, 8'h60, 32'h4, 32'h0, 5, lat);
    access(cache_pkg::write, 8'h61, 32'hc, 32'h1234_abcd, 3, lat);
    access(cache_pkg::read, 8'h62, 32'hc, 32'h0, 4, lat);
    end_test("back_pressure");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  // end of run after a timeout
  initial
  begin
    wait (timed_out);
    $display("checks %0d, errors %0d", checks, errors);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: flist.f
rtl/cache_pkg.sv
rtl/cache_tag_array.sv
rtl/cache_data_array.sv
rtl/cache_ctrl.sv
rtl/blocking_cache.sv
verif/tb_clk_gen.sv
verif/tb_mem_model.sv
verif/tb_blocking_cache.sv
